/* Bender.yml */
package:
  name: alu_vector

sources:
  - files:
      - aluPkg.sv
      - apbPkg.sv
      - aluLane.sv
      - laneDispatcher.sv
      - resultCollector.sv
      - aluVectorTop.sv
  - target: test
    files:
      - aluVectorTb.sv

/* aluLane.sv */
`timescale 1ns/1ns

module aluLane import aluPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  laneReqT req,
    output laneRspT rsp
);

    aluOpT                 op;
    logic [DataWidth-1:0]  srcA;
    logic [DataWidth-1:0]  srcB;
    logic [ShamtWidth-1:0] shamt;
    logic [DataWidth-1:0]  aluResult;
    logic                  opIllegal;

    // compare flags are signed except ltUnsigned
    logic ltSigned;
    logic ltUnsigned;
    logic isEqual;
    logic ltZero;
    logic leZero;

    logic                 rspValid;
    logic                 rspIllegal;
    logic [DataWidth-1:0] rspResult;

    assign op = aluOpT'(req.op);
    assign srcA = req.srcA;
    assign srcB = req.srcB;

    // shift amount comes from SrcA and the shifted value from SrcB
    assign shamt = srcA[ShamtWidth-1:0];

    assign ltSigned = $signed(srcA) < $signed(srcB);
    assign ltUnsigned = srcA < srcB;
    assign isEqual = srcA == srcB;
    assign ltZero = $signed(srcA) < 0;
    assign leZero = $signed(srcA) <= 0;

    always_comb begin
        aluResult = '0;
        opIllegal = 1'b0;
        case (op)
            OpAnd: begin
                aluResult = srcA & srcB;
            end
            OpOr: begin
                aluResult = srcA | srcB;
            end
            OpAdd: begin
                aluResult = srcA + srcB;
            end
            OpXor: begin
                aluResult = srcA ^ srcB;
            end
            OpSll: begin
                aluResult = srcB << shamt;
            end
            OpSrl: begin
                aluResult = srcB >> shamt;
            end
            OpSub: begin
                aluResult = srcA - srcB;
            end
            OpSlt: begin
                aluResult = DataWidth'(ltSigned);
            end
            OpSra: begin
                aluResult = $unsigned($signed(srcB) >>> shamt);
            end
            OpSltu: begin
                aluResult = DataWidth'(ltUnsigned);
            end
            OpEq: begin
                aluResult = DataWidth'(isEqual);
            end
            OpPassB: begin
                aluResult = srcB;
            end
            OpLtz: begin
                aluResult = DataWidth'(ltZero);
            end
            OpAdd4: begin
                // return address for jump-and-link
                aluResult = srcA + srcB + DataWidth'(4);
            end
            OpPassA: begin
                aluResult = srcA;
            end
            OpLez: begin
                aluResult = DataWidth'(leZero);
            end
            OpJConst: begin
                // word index to byte address
                aluResult = {3'b000, srcA[26:0], 2'b00};
            end
            default: begin
                // unknown code gives zero and flags the lane
                opIllegal = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rspValid <= 1'b0;
            rspIllegal <= 1'b0;
        end else begin
            rspValid <= req.valid;
            rspIllegal <= req.valid && opIllegal;
        end
    end

    always_ff @(posedge clk) begin
        if (req.valid) begin
            rspResult <= aluResult;
        end
    end

    assign rsp.valid = rspValid;
    assign rsp.illegal = rspIllegal;
    assign rsp.result = rspResult;

    // each start issues the lane for exactly one cycle
    reqSinglePulse: assert property (@(posedge clk) disable iff (reset)
        req.valid |=> !req.valid)
        else $error("lane request valid held for more than one cycle");

endmodule

/* aluPkg.sv */
package aluPkg;

    // datapath widths
    localparam int DataWidth = 32;
    localparam int OpWidth = 5;
    localparam int ShamtWidth = $clog2(DataWidth);

    // lanes issued together by one start command
    localparam int NumLanes = 4;

    // opcode encodings follow the MIPS-style control word
    // code 15 stays free and decodes as illegal
    typedef enum logic [OpWidth-1:0] {
        OpAnd    = 5'd0,
        OpOr     = 5'd1,
        OpAdd    = 5'd2,
        OpXor    = 5'd3,
        OpSll    = 5'd4,
        OpSrl    = 5'd5,
        OpSub    = 5'd6,
        OpSlt    = 5'd7,
        OpSra    = 5'd8,
        OpSltu   = 5'd9,
        OpEq     = 5'd10,
        OpPassB  = 5'd11,
        OpLtz    = 5'd12,
        OpAdd4   = 5'd13,
        OpPassA  = 5'd14,
        OpLez    = 5'd16,
        OpJConst = 5'd17
    } aluOpT;

    // request into one lane
    // op is kept raw so that unknown codes reach the lane
    typedef struct packed {
        logic                 valid;
        logic [OpWidth-1:0]   op;
        logic [DataWidth-1:0] srcA;
        logic [DataWidth-1:0] srcB;
    } laneReqT;

    // registered lane response
    typedef struct packed {
        logic                 valid;
        logic                 illegal;
        logic [DataWidth-1:0] result;
    } laneRspT;

endpackage

/* aluVectorTb.sv */
`timescale 1ns/1ns

module aluVectorTb import aluPkg::*, apbPkg::*; ();

    localparam int StatusBits = $bits(statusT);

    logic   clk;
    logic   reset;
    apbReqT apbReq;
    apbRspT apbRsp;

    logic [15:0] lfsr;
    int          cycles;
    int          cycleLimit;

    // one entry per vector line
    logic [OpWidth-1:0]   vecOp [$];
    logic [DataWidth-1:0] vecSrcA [$];
    logic [DataWidth-1:0] vecSrcB [$];
    logic [DataWidth-1:0] vecExp [$];
    logic                 vecIllegal [$];

    aluVectorTop UUT (
        .clk    (clk),
        .reset  (reset),
        .apbReq (apbReq),
        .apbRsp (apbRsp)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycleLimit > 0 && cycles >= cycleLimit) begin
            reportProblem($sformatf("timeout, run still going after %0d cycles", cycles));
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrStep(input logic [15:0] state);
        return {state[0] ^ state[2] ^ state[3] ^ state[5], state[15:1]};
    endfunction

    function automatic logic [AddrWidth-1:0] laneSlot(input int lane,
                                                      input logic [AddrWidth-1:0] offset);
        return LaneBase + AddrWidth'(lane) * LaneStride + offset;
    endfunction

    task automatic drawBits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            lfsr = lfsrStep(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic reportMismatch(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        $display("Test failed");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic reportProblem(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "run aborted");
    endtask

    task automatic checkWord(input logic [DataWidth-1:0] actual,
                             input logic [DataWidth-1:0] expected, input string what);
        if (actual !== expected) begin
            reportMismatch($sformatf("%s expected %h, got %h", what, expected, actual));
        end
    endtask

    task automatic checkStatus(input statusT actual, input statusT expected);
        if (actual !== expected) begin
            reportMismatch($sformatf("status expected done %b illegal %b busy %b, got %b %b %b",
                expected.doneBits, expected.illegalBits, expected.busy,
                actual.doneBits, actual.illegalBits, actual.busy));
        end
    endtask

    task automatic checkSlverr(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            reportMismatch($sformatf("%s pslverr expected %b, got %b", what, expected, actual));
        end
    endtask

    task automatic checkReady(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            reportMismatch($sformatf("%s pready expected %b, got %b", what, expected, actual));
        end
    endtask

    // starts and ends 2 ns after a rising edge
    task automatic apbAccess(input logic write, input logic [AddrWidth-1:0] addr,
                             input logic [ApbDataWidth-1:0] wdata,
                             output logic [ApbDataWidth-1:0] rdata, output logic slverr);
        apbReq.psel = 1'b1;
        apbReq.penable = 1'b0;
        apbReq.pwrite = write;
        apbReq.paddr = addr;
        apbReq.pwdata = write ? wdata : '0;
        @(posedge clk);
        #2;
        apbReq.penable = 1'b1;
        @(negedge clk);
        rdata = apbRsp.prdata;
        slverr = apbRsp.pslverr;
        // no wait states
        checkReady(apbRsp.pready, 1'b1, $sformatf("access to %h", addr));
        @(posedge clk);
        #2;
        apbReq = '0;
    endtask

    task automatic writeReg(input logic [AddrWidth-1:0] addr,
                            input logic [ApbDataWidth-1:0] data, input logic expectErr);
        logic [ApbDataWidth-1:0] rdata;
        logic                    slverr;
        apbAccess(1'b1, addr, data, rdata, slverr);
        checkSlverr(slverr, expectErr, $sformatf("write to %h", addr));
    endtask

    task automatic readReg(input logic [AddrWidth-1:0] addr,
                           output logic [ApbDataWidth-1:0] rdata);
        logic slverr;
        apbAccess(1'b0, addr, '0, rdata, slverr);
        checkSlverr(slverr, 1'b0, $sformatf("read of %h", addr));
    endtask

    task automatic idleCycles(input int count);
        repeat (count) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic loadVectors();
        int          fd;
        int          got;
        string       line;
        logic [31:0] op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] e;
        logic [31:0] il;
        fd = $fopen("aluVectors.txt", "r");
        if (fd == 0) begin
            reportProblem("cannot open aluVectors.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            got = $sscanf(line, "%h %h %h %h %h", op, a, b, e, il);
            if (got != 5) begin
                reportProblem($sformatf("bad vector line: %s", line));
            end
            // unused code 15 and everything above JCONST must be flagged
            if (il[0] != (op == 15 || op > 17)) begin
                reportProblem($sformatf("illegal flag does not match opcode %h in vectors", op));
            end
            vecOp.push_back(op[OpWidth-1:0]);
            vecSrcA.push_back(a);
            vecSrcB.push_back(b);
            vecExp.push_back(e);
            vecIllegal.push_back(il[0]);
        end
        $fclose(fd);
        if (vecOp.size() == 0 || vecOp.size() % NumLanes != 0) begin
            reportProblem("vector count is not a whole number of batches");
        end
    endtask

    task automatic checkAfterReset();
        logic [ApbDataWidth-1:0] rdata;
        readReg(StatusAddr, rdata);
        checkWord(rdata, '0, "status after reset");
        for (int i = 0; i < NumLanes; i++) begin
            readReg(ResultBase + AddrWidth'(i) * ResultStride, rdata);
            checkWord(rdata, '0, $sformatf("lane %0d result after reset", i));
        end
    endtask

    task automatic checkUnmapped();
        logic [ApbDataWidth-1:0] rdata;
        logic                    slverr;
        logic [AddrWidth-1:0]    holes [3];
        holes = '{8'h0C, 8'h48, 8'h60};
        foreach (holes[i]) begin
            apbAccess(1'b0, holes[i], '0, rdata, slverr);
            checkSlverr(slverr, 1'b1, $sformatf("read of unmapped %h", holes[i]));
            checkWord(rdata, '0, $sformatf("read data of unmapped %h", holes[i]));
            writeReg(holes[i], 32'hA5A5A5A5, 1'b1);
        end
        // opcode wider than five bits
        writeReg(laneSlot(1, OpOffset), 32'h0000_0020, 1'b1);
    endtask

    task automatic runBatch(input int base);
        int                      order [NumLanes];
        bit                      used [NumLanes];
        int                      pick;
        int                      gap;
        int                      lane;
        logic [ApbDataWidth-1:0] rdata;
        statusT                  expStatus;
        foreach (used[i]) begin
            used[i] = 1'b0;
        end
        for (int pos = 0; pos < NumLanes; pos++) begin
            drawBits(2, pick);
            while (used[pick]) begin
                pick = (pick + 1) % NumLanes;
            end
            used[pick] = 1'b1;
            order[pos] = pick;
        end
        for (int pos = 0; pos < NumLanes; pos++) begin
            lane = order[pos];
            drawBits(2, gap);
            idleCycles(gap);
            writeReg(laneSlot(lane, SrcAOffset), vecSrcA[base + lane], 1'b0);
            writeReg(laneSlot(lane, SrcBOffset), vecSrcB[base + lane], 1'b0);
            writeReg(laneSlot(lane, OpOffset), ApbDataWidth'(vecOp[base + lane]), 1'b0);
        end
        writeReg(CtrlAddr, 32'h1, 1'b0);
        // back to back so the lanes are still running
        writeReg(CtrlAddr, 32'h1, 1'b1);
        do begin
            readReg(StatusAddr, rdata);
        end while (rdata[0]);
        expStatus.doneBits = '1;
        expStatus.busy = 1'b0;
        for (int i = 0; i < NumLanes; i++) begin
            expStatus.illegalBits[i] = vecIllegal[base + i];
        end
        checkStatus(statusT'(rdata[StatusBits-1:0]), expStatus);
        checkWord(rdata >> StatusBits, '0, "status upper bits");
        for (int i = 0; i < NumLanes; i++) begin
            readReg(ResultBase + AddrWidth'(i) * ResultStride, rdata);
            checkWord(rdata, vecExp[base + i],
                $sformatf("vector %0d opcode %h result", base + i, vecOp[base + i]));
        end
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        apbReq = '0;
        lfsr = 16'd55;
        cycles = 0;
        cycleLimit = 0;
        loadVectors();
        cycleLimit = 60 * (vecOp.size() / NumLanes) + 200;
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
        checkAfterReset();
        checkUnmapped();
        for (int b = 0; b < vecOp.size(); b += NumLanes) begin
            runBatch(b);
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* aluVectorTop.f */
aluPkg.sv
apbPkg.sv
aluLane.sv
laneDispatcher.sv
resultCollector.sv
aluVectorTop.sv
aluVectorTb.sv

/* aluVectorTop.sv */
`timescale 1ns/1ns

module aluVectorTop import aluPkg::*, apbPkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  apbReqT apbReq,
    output apbRspT apbRsp
);

    laneReqT              laneReq [NumLanes];
    laneRspT              laneRsp [NumLanes];
    logic                 issue;
    statusT               status;
    logic [DataWidth-1:0] results [NumLanes];

    laneDispatcher dispatcher (
        .clk     (clk),
        .reset   (reset),
        .apbReq  (apbReq),
        .apbRsp  (apbRsp),
        .laneReq (laneReq),
        .issue   (issue),
        .status  (status),
        .results (results)
    );

    // identical lanes, all started together
    for (genvar i = 0; i < NumLanes; i++) begin : genLanes
        aluLane lane (
            .clk   (clk),
            .reset (reset),
            .req   (laneReq[i]),
            .rsp   (laneRsp[i])
        );
    end

    resultCollector collector (
        .clk     (clk),
        .reset   (reset),
        .issue   (issue),
        .laneRsp (laneRsp),
        .status  (status),
        .results (results)
    );

endmodule

/* aluVectors.txt */
# opcode srcA srcB expectedResult illegalFlag, all hex
# four lines form one batch, line order is lane 0 to 3
00 F0F0F0F0 FF00FF00 F000F000 0
01 F0F0F0F0 0F0F0000 FFFFF0F0 0
02 7FFFFFFF 00000001 80000000 0
03 AAAA5555 FFFF0000 55555555 0
04 00000004 0000000F 000000F0 0
05 00000008 80000000 00800000 0
06 00000005 00000007 FFFFFFFE 0
07 FFFFFFFF 00000001 00000001 0
08 00000004 80000000 F8000000 0
09 FFFFFFFF 00000001 00000000 0
0A 12345678 12345678 00000001 0
0B DEADBEEF CAFEF00D CAFEF00D 0
0C 80000000 00000000 00000001 0
0D 00400000 00000010 00400014 0
0E DEADBEEF 00000000 DEADBEEF 0
10 00000000 00000000 00000001 0
11 FC123456 00000000 1048D158 0
0F 11111111 22222222 00000000 1
07 00000001 FFFFFFFF 00000000 0
08 0000001F FFFFFFFE FFFFFFFF 0
12 33333333 44444444 00000000 1
09 00000001 FFFFFFFF 00000001 0
1F 55555555 66666666 00000000 1
10 FFFFFFFF 00000000 00000001 0

/* apbPkg.sv */
package apbPkg;

    localparam int AddrWidth = 8;
    localparam int ApbDataWidth = 32;

    // lane slots, one 16-byte window per lane
    localparam logic [AddrWidth-1:0] LaneBase   = 8'h00;
    localparam logic [AddrWidth-1:0] LaneStride = 8'h10;
    localparam logic [AddrWidth-1:0] SrcAOffset = 8'h00;
    localparam logic [AddrWidth-1:0] SrcBOffset = 8'h04;
    localparam logic [AddrWidth-1:0] OpOffset   = 8'h08;

    // control, status and result words
    localparam logic [AddrWidth-1:0] CtrlAddr     = 8'h40;
    localparam logic [AddrWidth-1:0] StatusAddr   = 8'h44;
    localparam logic [AddrWidth-1:0] ResultBase   = 8'h50;
    localparam logic [AddrWidth-1:0] ResultStride = 8'h04;

    typedef struct packed {
        logic                    psel;
        logic                    penable;
        logic                    pwrite;
        logic [AddrWidth-1:0]    paddr;
        logic [ApbDataWidth-1:0] pwdata;
    } apbReqT;

    typedef struct packed {
        logic                    pready;
        logic                    pslverr;
        logic [ApbDataWidth-1:0] prdata;
    } apbRspT;

    // read back zero-extended at StatusAddr
    typedef struct packed {
        logic [aluPkg::NumLanes-1:0] doneBits;
        logic [aluPkg::NumLanes-1:0] illegalBits;
        logic                        busy;
    } statusT;

endpackage

/* laneDispatcher.sv */
`timescale 1ns/1ns

module laneDispatcher import aluPkg::*, apbPkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  apbReqT               apbReq,
    output apbRspT               apbRsp,
    output laneReqT              laneReq [NumLanes],
    output logic                 issue,
    input  statusT               status,
    input  logic [DataWidth-1:0] results [NumLanes]
);

    typedef enum logic {
        Idle,
        Running
    } stateT;

    stateT state;
    stateT stateNext;

    logic access;
    logic wrAccess;
    logic [NumLanes-1:0] hitSrcA;
    logic [NumLanes-1:0] hitSrcB;
    logic [NumLanes-1:0] hitOp;
    logic [NumLanes-1:0] hitResult;
    logic hitCtrl;
    logic hitStatus;
    logic mapped;
    logic batchDone;
    logic running;
    logic startAccept;
    logic slvErr;
    logic [ApbDataWidth-1:0] rdData;
    statusT statusRead;

    // operand and opcode storage, plus the issue-cycle valid bits
    logic [NumLanes-1:0]  reqValid;
    logic [OpWidth-1:0]   opReg [NumLanes];
    logic [DataWidth-1:0] srcAReg [NumLanes];
    logic [DataWidth-1:0] srcBReg [NumLanes];

    function automatic logic [AddrWidth-1:0] slotAddr(input int lane,
                                                      input logic [AddrWidth-1:0] offset);
        return LaneBase + AddrWidth'(lane) * LaneStride + offset;
    endfunction

    assign access = apbReq.psel && apbReq.penable;
    assign wrAccess = access && apbReq.pwrite;

    always_comb begin
        for (int i = 0; i < NumLanes; i++) begin
            hitSrcA[i] = apbReq.paddr == slotAddr(i, SrcAOffset);
            hitSrcB[i] = apbReq.paddr == slotAddr(i, SrcBOffset);
            hitOp[i] = apbReq.paddr == slotAddr(i, OpOffset);
            hitResult[i] = apbReq.paddr == ResultBase + AddrWidth'(i) * ResultStride;
        end
    end

    assign hitCtrl = apbReq.paddr == CtrlAddr;
    assign hitStatus = apbReq.paddr == StatusAddr;
    assign mapped = |{hitSrcA, hitSrcB, hitOp, hitResult, hitCtrl, hitStatus};

    // issue still high means the done bits are from the previous batch
    assign batchDone = (&status.doneBits) && !issue;
    assign running = (state == Running) && !batchDone;

    assign startAccept = wrAccess && hitCtrl && !running && apbReq.pwdata[0];

    assign slvErr = (access && !mapped)
        || (wrAccess && hitCtrl && running)
        || (wrAccess && (|hitOp) && (apbReq.pwdata[ApbDataWidth-1:OpWidth] != '0));

    always_comb begin
        stateNext = state;
        unique case (state)
            Idle: if (startAccept) stateNext = Running;
            Running: if (!startAccept && batchDone) stateNext = Idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= Idle;
            issue <= 1'b0;
            reqValid <= '0;
        end else begin
            state <= stateNext;
            issue <= startAccept;
            reqValid <= {NumLanes{startAccept}};
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NumLanes; i++) begin
            if (wrAccess && hitSrcA[i]) srcAReg[i] <= apbReq.pwdata;
            if (wrAccess && hitSrcB[i]) srcBReg[i] <= apbReq.pwdata;
            // upper bits only raise pslverr
            if (wrAccess && hitOp[i]) opReg[i] <= apbReq.pwdata[OpWidth-1:0];
        end
    end

    always_comb begin
        for (int i = 0; i < NumLanes; i++) begin
            laneReq[i].valid = reqValid[i];
            laneReq[i].op = opReg[i];
            laneReq[i].srcA = srcAReg[i];
            laneReq[i].srcB = srcBReg[i];
        end
    end

    // busy as the host sees it
    assign statusRead.doneBits = status.doneBits;
    assign statusRead.illegalBits = status.illegalBits;
    assign statusRead.busy = running;

    always_comb begin
        rdData = '0;
        if (access && !apbReq.pwrite) begin
            for (int i = 0; i < NumLanes; i++) begin
                if (hitSrcA[i]) rdData = srcAReg[i];
                if (hitSrcB[i]) rdData = srcBReg[i];
                if (hitOp[i]) rdData = ApbDataWidth'(opReg[i]);
                if (hitResult[i]) rdData = results[i];
            end
            if (hitStatus) rdData = ApbDataWidth'(statusRead);
        end
    end

    assign apbRsp.pready = 1'b1;
    assign apbRsp.pslverr = slvErr;
    assign apbRsp.prdata = rdData;

endmodule

/* resultCollector.sv */
`timescale 1ns/1ns

module resultCollector import aluPkg::*, apbPkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 issue,
    input  laneRspT              laneRsp [NumLanes],
    output statusT               status,
    output logic [DataWidth-1:0] results [NumLanes]
);

    logic [NumLanes-1:0] rspValid;
    logic [NumLanes-1:0] doneBits;
    logic [NumLanes-1:0] illegalBits;
    logic                busy;

    always_comb begin
        for (int i = 0; i < NumLanes; i++) begin
            rspValid[i] = laneRsp[i].valid;
        end
    end

    // results read zero until the first batch lands
    always_ff @(posedge clk) begin
        if (reset) begin
            doneBits <= '0;
            illegalBits <= '0;
            busy <= 1'b0;
            for (int i = 0; i < NumLanes; i++) begin
                results[i] <= '0;
            end
        end else if (issue) begin
            // new batch, forget the old flags
            doneBits <= '0;
            illegalBits <= '0;
            busy <= 1'b1;
        end else begin
            for (int i = 0; i < NumLanes; i++) begin
                if (rspValid[i]) begin
                    doneBits[i] <= 1'b1;
                    illegalBits[i] <= laneRsp[i].illegal;
                    results[i] <= laneRsp[i].result;
                end
            end
            if (&(doneBits | rspValid)) begin
                busy <= 1'b0;
            end
        end
    end

    assign status.doneBits = doneBits;
    assign status.illegalBits = illegalBits;
    assign status.busy = busy;

    // a response only comes back for an issued batch
    noRspWhenIdle: assert property (@(posedge clk) disable iff (reset)
        (|rspValid) |-> busy)
        else $error("lane response while collector idle");

    // dispatcher issues every lane in the same cycle
    lanesInStep: assert property (@(posedge clk) disable iff (reset)
        (|rspValid) |-> (&rspValid))
        else $error("lane responses out of step");

endmodule
